//--- Makefile
# Verilator build of the VGA frame-buffer testbench
SIM = obj_dir/vga_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module vga_tb --Mdir obj_dir -o vga_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sources.f
src/vga_pkg.sv
src/vga_axil_slave.sv
src/vga_mem.sv
src/vga_timing.sv
src/vga_fetch.sv
src/vga_pixel_out.sv
src/vga_top.sv
verif/vga_checker.sv
verif/vga_tb.sv

//--- src/vga_axil_slave.sv
`timescale 1ns/1ps

module vga_axil_slave #(
    parameter int axi_addr_w = 16
) (
    input  logic                          clock_a,
    input  logic                          rst_n,
    // Write address
    input  logic [axi_addr_w-1:0]         awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    // Write data
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    // Write response
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // Read address
    input  logic [axi_addr_w-1:0]         araddr,
    input  logic                          arvalid,
    output logic                          arready,
    // Read data
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    // Core port of the frame buffer
    output logic [vga_pkg::fb_addr_w-1:0] address_a,
    output logic [31:0]                   data_a,
    output logic [3:0]                    byteena_a,
    output logic                          wren_a,
    input  logic [31:0]                   q_a,
    // Colour registers
    output vga_pkg::color_t               fg_color,
    output vga_pkg::color_t               bg_color
);
    import vga_pkg::*;

    // Target of a request
    typedef enum logic [1:0] {sel_fb, sel_fg, sel_bg, sel_err} sel_t;

    sel_t aw_sel;
    sel_t ar_sel;
    sel_t rd_sel;
    logic wr_fire;
    logic rd_fire;
    logic rd_pend;

    // Address map decode
    function automatic sel_t decode(input logic [axi_addr_w-1:0] addr);
        sel_t sel;
        if (int'(addr) < fb_words * 4) begin
            sel = sel_fb;
        end else if (addr == axi_addr_w'(reg_fg_addr)) begin
            sel = sel_fg;
        end else if (addr == axi_addr_w'(reg_bg_addr)) begin
            sel = sel_bg;
        end else begin
            sel = sel_err;
        end
        return sel;
    endfunction

    assign aw_sel = decode(awaddr);
    assign ar_sel = decode(araddr);

    // ==============================
    // Handshakes
    // ==============================
    // AW and W taken together, blocked while B is pending
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    // Write wins the shared memory port
    assign rd_fire = arvalid && !rd_pend && !rvalid && !wr_fire;
    assign arready = rd_fire;

    // Memory port, word address from the byte address
    assign address_a = wr_fire ? awaddr[fb_addr_w+1:2] : araddr[fb_addr_w+1:2];
    assign data_a    = wdata;
    assign byteena_a = wstrb;
    assign wren_a    = wr_fire && (aw_sel == sel_fb);

    // ==============================
    // Write response and registers
    // ==============================
    always_ff @(posedge clock_a or negedge rst_n) begin
        if (!rst_n) begin
            bvalid   <= 1'b0;
            fg_color <= '0;
            bg_color <= '0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // Low strobe carries green and blue, next one red
            if (wr_fire && aw_sel == sel_fg) begin
                if (wstrb[0]) fg_color[7:0]  <= wdata[7:0];
                if (wstrb[1]) fg_color[11:8] <= wdata[11:8];
            end
            if (wr_fire && aw_sel == sel_bg) begin
                if (wstrb[0]) bg_color[7:0]  <= wdata[7:0];
                if (wstrb[1]) bg_color[11:8] <= wdata[11:8];
            end
        end
    end

    always_ff @(posedge clock_a) begin
        if (wr_fire) begin
            bresp <= (aw_sel == sel_err) ? resp_slverr : resp_okay;
        end
    end

    // ==============================
    // Read path
    // ==============================
    // Accept, then one cycle for q_a, then rvalid
    always_ff @(posedge clock_a or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rd_pend <= rd_fire;
            if (rd_pend) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_a) begin
        if (rd_fire) begin
            rd_sel <= ar_sel;
        end
        if (rd_pend) begin
            case (rd_sel)
                sel_fb:  rdata <= q_a;
                sel_fg:  rdata <= {20'd0, fg_color};
                sel_bg:  rdata <= {20'd0, bg_color};
                default: rdata <= '0;
            endcase
            rresp <= (rd_sel == sel_err) ? resp_slverr : resp_okay;
        end
    end

    // Responses held steady until taken
    a_b_hold: assert property (@(posedge clock_a) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));
    a_r_hold: assert property (@(posedge clock_a) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

//--- src/vga_fetch.sv
`timescale 1ns/1ps

module vga_fetch #(
    parameter int fb_words = vga_pkg::fb_words
) (
    input  logic                          clock_b,
    input  logic                          rst_n,
    // From timing
    input  logic [9:0]                    h_count,
    input  logic [9:0]                    v_count,
    input  logic                          raw_hsync,
    input  logic                          raw_vsync,
    input  logic                          raw_active,
    // To memory
    output logic [vga_pkg::fb_addr_w-1:0] address_b,
    // Aligned with q_b
    output logic [4:0]                    bit_idx,
    output logic                          d_hsync,
    output logic                          d_vsync,
    output logic                          d_active
);
    import vga_pkg::*;

    int         word_full;
    logic       addr_ok;
    logic [1:0] hs_dly;
    logic [1:0] vs_dly;
    logic [1:0] act_dly;
    logic [4:0] idx_q1;

    // 32 pixels per word, 20 words per line
    assign word_full = int'(v_count) * words_per_line + int'(h_count[9:5]);
    // Blanking or a short buffer reads word 0
    assign addr_ok   = raw_active && (word_full < fb_words);

    // ==============================
    // Address register
    // ==============================
    always_ff @(posedge clock_b or negedge rst_n) begin
        if (!rst_n) begin
            address_b <= '0;
        end else begin
            address_b <= addr_ok ? fb_addr_w'(word_full) : '0;
        end
    end

    // Flag delay line, two stages
    always_ff @(posedge clock_b or negedge rst_n) begin
        if (!rst_n) begin
            hs_dly  <= 2'b11;
            vs_dly  <= 2'b11;
            act_dly <= 2'b00;
        end else begin
            hs_dly  <= {hs_dly[0], raw_hsync};
            vs_dly  <= {vs_dly[0], raw_vsync};
            act_dly <= {act_dly[0], raw_active};
        end
    end

    // Bit index follows the same two stages
    always_ff @(posedge clock_b) begin
        idx_q1  <= h_count[4:0];
        bit_idx <= idx_q1;
    end

    assign d_hsync  = hs_dly[1];
    assign d_vsync  = vs_dly[1];
    assign d_active = act_dly[1];

endmodule

//--- src/vga_mem.sv
`timescale 1ns/1ps

module vga_mem #(
    parameter int fb_words = vga_pkg::fb_words
) (
    input  logic                          clock_a,
    input  logic                          clock_b,
    // Core write
    input  logic [31:0]                   data_a,
    input  logic [vga_pkg::fb_addr_w-1:0] address_a,
    input  logic [3:0]                    byteena_a,
    input  logic                          wren_a,
    // Core read
    output logic [31:0]                   q_a,
    // Display read
    input  logic [vga_pkg::fb_addr_w-1:0] address_b,
    output logic [31:0]                   q_b
);
    import vga_pkg::*;

    localparam int fb_bytes = fb_words * 4;

    // Byte array, 80 bytes per line
    logic [7:0] mem [fb_bytes];

    // Word aligned byte addresses
    logic [fb_addr_w+1:0] byte_a;
    logic [fb_addr_w+1:0] byte_b;

    assign byte_a = {address_a, 2'b00};
    assign byte_b = {address_b, 2'b00};

    // ==============================
    // Core side, clock_a
    // ==============================
    always_ff @(posedge clock_a) begin
        // Per-lane byte writes, lane 0 is the low byte
        for (int lane = 0; lane < 4; lane++) begin
            if (wren_a && byteena_a[lane]) begin
                mem[int'(byte_a) + lane] <= data_a[8*lane +: 8];
            end
        end
        // Registered read, old data on a same-cycle write
        q_a <= {mem[int'(byte_a) + 3], mem[int'(byte_a) + 2],
                mem[int'(byte_a) + 1], mem[int'(byte_a)]};
    end

    // ==============================
    // Display side, clock_b
    // ==============================
    always_ff @(posedge clock_b) begin
        q_b <= {mem[int'(byte_b) + 3], mem[int'(byte_b) + 2],
                mem[int'(byte_b) + 1], mem[int'(byte_b)]};
    end

    // Slave decode keeps writes inside the buffer
    a_wr_range: assert property (@(posedge clock_a)
        wren_a |-> int'(address_a) < fb_words);

endmodule

//--- src/vga_pixel_out.sv
`timescale 1ns/1ps

module vga_pixel_out (
    input  logic            clock_b,
    input  logic            rst_n,
    // Fetched word and aligned flags
    input  logic [31:0]     q_b,
    input  logic [4:0]      bit_idx,
    input  logic            d_hsync,
    input  logic            d_vsync,
    input  logic            d_active,
    // Quasi-static colours from clock_a
    input  vga_pkg::color_t fg_color,
    input  vga_pkg::color_t bg_color,
    // Pins
    output logic            hsync,
    output logic            vsync,
    output logic            de,
    output logic [3:0]      red,
    output logic [3:0]      green,
    output logic [3:0]      blue
);
    import vga_pkg::*;

    color_t pix_color;

    // Set bit shows foreground, black in blanking
    assign pix_color = !d_active    ? color_t'(12'd0) :
                       q_b[bit_idx] ? fg_color : bg_color;

    // ==============================
    // Output registers
    // ==============================
    always_ff @(posedge clock_b or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            hsync <= d_hsync;
            vsync <= d_vsync;
            de    <= d_active;
            red   <= pix_color.red;
            green <= pix_color.green;
            blue  <= pix_color.blue;
        end
    end

    a_blank_black: assert property (@(posedge clock_b) disable iff (!rst_n)
        !de |-> {red, green, blue} == 12'd0);

endmodule

//--- src/vga_pkg.sv
package vga_pkg;

    // ==============================
    // Display timing, 640x480 at 60 Hz
    // ==============================

    // Horizontal, in pixels
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;

    // Vertical, in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;

    // ==============================
    // Frame buffer geometry
    // ==============================
    // 1 bit per pixel, 80 bytes per line
    localparam int fb_words       = 9600;
    localparam int words_per_line = 20;
    localparam int fb_addr_w      = 14;

    // Colour register byte addresses
    localparam logic [15:0] reg_fg_addr = 16'hA000;
    localparam logic [15:0] reg_bg_addr = 16'hA004;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } color_t;

endpackage

//--- src/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic       clock_b,
    input  logic       rst_n,
    // Raster position
    output logic [9:0] h_count,
    output logic [9:0] v_count,
    // Undelayed flags, syncs active low
    output logic       raw_hsync,
    output logic       raw_vsync,
    output logic       raw_active
);
    import vga_pkg::*;

    // Totals, 800 by 525
    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // Sync windows
    localparam int hs_start = h_active + h_front;
    localparam int hs_end   = hs_start + h_sync;
    localparam int vs_start = v_active + v_front;
    localparam int vs_end   = vs_start + v_sync;

    logic h_last;
    logic v_last;

    assign h_last = (int'(h_count) == h_total - 1);
    assign v_last = (int'(v_count) == v_total - 1);

    // ==============================
    // Counters
    // ==============================
    always_ff @(posedge clock_b or negedge rst_n) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            // Pixel counter wraps every line
            if (h_last) begin
                h_count <= '0;
            end else begin
                h_count <= h_count + 10'd1;
            end
            // Line counter steps at end of line
            if (h_last) begin
                if (v_last) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 10'd1;
                end
            end
        end
    end

    // ==============================
    // Window decode
    // ==============================
    assign raw_hsync  = !(int'(h_count) >= hs_start && int'(h_count) < hs_end);
    assign raw_vsync  = !(int'(v_count) >= vs_start && int'(v_count) < vs_end);
    assign raw_active = (int'(h_count) < h_active) && (int'(v_count) < v_active);

    // Counters never leave the raster
    a_count_range: assert property (@(posedge clock_b) disable iff (!rst_n)
        int'(h_count) < h_total && int'(v_count) < v_total);

endmodule

//--- src/vga_top.sv
`timescale 1ns/1ps

module vga_top #(
    parameter int axi_addr_w = 16,
    parameter int fb_words   = vga_pkg::fb_words
) (
    input  logic                  clock_a,
    input  logic                  clock_b,
    input  logic                  rst_n,
    // AXI4-Lite slave, clock_a
    input  logic [axi_addr_w-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [axi_addr_w-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // VGA pins, clock_b
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de,
    output logic [3:0]            red,
    output logic [3:0]            green,
    output logic [3:0]            blue
);
    import vga_pkg::*;

    // Core port
    logic [fb_addr_w-1:0] address_a;
    logic [31:0]          data_a;
    logic [3:0]           byteena_a;
    logic                 wren_a;
    logic [31:0]          q_a;
    color_t               fg_color;
    color_t               bg_color;

    // Display pipeline
    logic [9:0]           h_count;
    logic [9:0]           v_count;
    logic                 raw_hsync;
    logic                 raw_vsync;
    logic                 raw_active;
    logic [fb_addr_w-1:0] address_b;
    logic [31:0]          q_b;
    logic [4:0]           bit_idx;
    logic                 d_hsync;
    logic                 d_vsync;
    logic                 d_active;

    vga_axil_slave #(.axi_addr_w(axi_addr_w)) u_vga_axil_slave (
        .clock_a, .rst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .address_a, .data_a, .byteena_a, .wren_a, .q_a,
        .fg_color, .bg_color
    );

    vga_mem #(.fb_words(fb_words)) u_vga_mem (
        .clock_a, .clock_b,
        .data_a, .address_a, .byteena_a, .wren_a, .q_a,
        .address_b, .q_b
    );

    // Stage 1
    vga_timing u_vga_timing (
        .clock_b, .rst_n,
        .h_count, .v_count, .raw_hsync, .raw_vsync, .raw_active
    );

    // Stage 2
    vga_fetch #(.fb_words(fb_words)) u_vga_fetch (
        .clock_b, .rst_n,
        .h_count, .v_count, .raw_hsync, .raw_vsync, .raw_active,
        .address_b, .bit_idx, .d_hsync, .d_vsync, .d_active
    );

    // Stage 4, stage 3 is the memory read
    vga_pixel_out u_vga_pixel_out (
        .clock_b, .rst_n,
        .q_b, .bit_idx, .d_hsync, .d_vsync, .d_active,
        .fg_color, .bg_color,
        .hsync, .vsync, .de, .red, .green, .blue
    );

endmodule

//--- verif/vga_checker.sv
`timescale 1ns/1ps

module vga_checker (
    input logic        clock_a,
    input logic        clock_b,
    input logic        rst_n,
    input logic        awready,
    input logic        wready,
    input logic        arready,
    input logic [1:0]  bresp,
    input logic        bvalid,
    input logic        bready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        rvalid,
    input logic        rready,
    input logic        hsync,
    input logic        vsync,
    input logic        de,
    input logic [3:0]  red,
    input logic [3:0]  green,
    input logic [3:0]  blue
);
    int          errors;
    int          tests;
    int          err_base;
    int          frames;
    // Expected AXI responses, in order
    logic [1:0]  b_exp_q[$];
    logic [31:0] r_data_q[$];
    logic [1:0]  r_resp_q[$];
    // Listed pixels
    int          pix_x[$];
    int          pix_y[$];
    logic [11:0] pix_c[$];
    int          pix_armed[$];
    int          pix_done[$];
    // AXI hold tracking
    bit          b_hold;
    bit          r_hold;
    logic [1:0]  bresp_prev;
    logic [1:0]  rresp_prev;
    logic [31:0] rdata_prev;
    // Raster tracking
    int          cyc;
    int          hs_fall_cyc;
    bit          hs_fall_seen;
    int          de_rise_cyc;
    int          vs_fall_cyc;
    int          vs_low;
    int          de_lines;
    int          line;
    int          x;
    logic        hs_prev;
    logic        vs_prev;
    logic        de_prev;

    initial begin
        errors  = 0;
        tests   = 0;
        frames  = 0;
        hs_prev = 1'b1;
        vs_prev = 1'b1;
        de_prev = 1'b0;
        line    = -1;
    end

    function automatic void compare(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endfunction

    function automatic void fail(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endfunction

    function automatic void finish_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_base) ? "pass" : "fail");
        err_base = errors;
    endfunction

    // ==============================
    // Calls from the testbench
    // ==============================
    task automatic check_idle();
        compare("hsync", hsync, 1);
        compare("vsync", vsync, 1);
        compare("de", de, 0);
        compare("colour", {red, green, blue}, 0);
        compare("awready", awready, 0);
        compare("wready", wready, 0);
        compare("arready", arready, 0);
        compare("bvalid", bvalid, 0);
        compare("rvalid", rvalid, 0);
        finish_test("reset state");
    endtask

    task automatic expect_write(input logic [1:0] resp);
        b_exp_q.push_back(resp);
    endtask

    task automatic expect_read(input logic [31:0] data, input logic [1:0] resp);
        r_data_q.push_back(data);
        r_resp_q.push_back(resp);
    endtask

    task automatic expect_pixel(input int px, input int py, input logic [11:0] c);
        pix_x.push_back(px);
        pix_y.push_back(py);
        pix_c.push_back(c);
        pix_armed.push_back(0);
        pix_done.push_back(0);
    endtask

    task automatic final_check();
        foreach (pix_done[i]) begin
            if (!pix_done[i]) fail($sformatf("pixel (%0d,%0d) was never shown",
                                             pix_x[i], pix_y[i]));
        end
        if (b_exp_q.size() != 0 || r_data_q.size() != 0) fail("AXI responses missing");
    endtask

    task automatic report();
        $display("tests %0d, errors %0d", tests, errors);
    endtask

    // ==============================
    // AXI responses, clock_a
    // ==============================
    always @(posedge clock_a) begin
        if (rst_n) begin
            // AW and W are always taken in the same cycle
            if (awready != wready) fail("awready and wready did not rise together");
            if (bvalid && bready) begin
                if (b_exp_q.size() == 0) fail("write response with none expected");
                else compare("bresp", bresp, b_exp_q.pop_front());
            end
            if (rvalid && rready) begin
                if (r_data_q.size() == 0) begin
                    fail("read response with none expected");
                end else begin
                    compare("rdata", rdata, r_data_q.pop_front());
                    compare("rresp", rresp, r_resp_q.pop_front());
                end
            end
            // Stalled responses keep valid and payload
            if (b_hold) begin
                if (!bvalid) fail("bvalid dropped before bready");
                compare("bresp held", bresp, bresp_prev);
            end
            if (r_hold) begin
                if (!rvalid) fail("rvalid dropped before rready");
                compare("rdata held", rdata, rdata_prev);
                compare("rresp held", rresp, rresp_prev);
            end
            b_hold     = bvalid && !bready;
            r_hold     = rvalid && !rready;
            bresp_prev = bresp;
            rresp_prev = rresp;
            rdata_prev = rdata;
        end
    end

    // ==============================
    // Raster and pixels, clock_b
    // ==============================
    always @(posedge clock_b) begin
        if (rst_n) begin
            cyc++;
            // Line period and sync width
            if (!hsync && hs_prev) begin
                if (hs_fall_seen) compare("hsync period", cyc - hs_fall_cyc, 800);
                hs_fall_seen = 1'b1;
                hs_fall_cyc  = cyc;
            end
            if (hsync && !hs_prev && hs_fall_seen) begin
                compare("hsync low cycles", cyc - hs_fall_cyc, 96);
            end
            if (de && !de_prev) begin
                de_rise_cyc = cyc;
                line++;
                x = 0;
                if (frames == 1) de_lines++;
            end
            if (!de && de_prev) compare("de high cycles", cyc - de_rise_cyc, 640);
            // Frame boundary on falling vsync
            if (!vsync && vs_prev) begin
                if (frames == 1) begin
                    compare("frame cycles", cyc - vs_fall_cyc, 420000);
                    compare("vsync low cycles", vs_low, 2 * 800);
                    compare("de lines", de_lines, 480);
                    finish_test("raster timing");
                end
                foreach (pix_armed[i]) begin
                    if (pix_armed[i] && !pix_done[i]) begin
                        fail($sformatf("pixel (%0d,%0d) missed in its frame",
                                       pix_x[i], pix_y[i]));
                        pix_done[i] = 1;
                    end
                    pix_armed[i] = 1;
                end
                frames++;
                vs_fall_cyc = cyc;
                vs_low      = 0;
                de_lines    = 0;
                line        = -1;
            end
            if (!vsync) vs_low++;
            if (de) begin
                foreach (pix_x[i]) begin
                    if (pix_armed[i] && !pix_done[i] && pix_x[i] == x && pix_y[i] == line) begin
                        compare($sformatf("colour at (%0d,%0d)", x, line),
                                {red, green, blue}, pix_c[i]);
                        pix_done[i] = 1;
                        finish_test($sformatf("pixel (%0d,%0d)", x, line));
                    end
                end
                x++;
            end
            hs_prev = hsync;
            vs_prev = vsync;
            de_prev = de;
        end
    end

endmodule

//--- verif/vga_input.txt
# W addr data strobe resp | R addr data resp | P x y colour | F waits for a frame
# All fields hex except x and y of P, which are decimal
W 0000 44332211 f 0
W 0000 aabbccdd 5 0
R 0000 44bb22dd 0
W 9600 12345678 f 2
R 9600 00000000 2
W b000 ffffffff f 2
R a008 00000000 2
R 0000 44bb22dd 0
W a000 00000f80 3 0
W a004 00000025 1 0
R a000 00000f80 0
R a004 00000025 0
W 1f64 0000a500 2 0
W 95fc 80000000 8 0
P 0 0 f80
P 1 0 025
P 8 0 025
P 9 0 f80
P 24 0 025
P 26 0 f80
P 296 100 f80
P 300 100 025
P 301 100 f80
P 638 479 025
P 639 479 f80
F

//--- verif/vga_tb.sv
`timescale 1ns/1ps

module vga_tb;

    // One 640x480 frame in clock_b cycles
    localparam int frame_cycles = 420000;

    logic        clock_a;
    logic        clock_b;
    logic        rst_n;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;

    // Parsed command lines
    byte         cmd_q[$];
    logic [31:0] f1_q[$];
    logic [31:0] f2_q[$];
    logic [31:0] f3_q[$];
    logic [31:0] f4_q[$];
    bit          load_failed;
    int          limit;
    int          cycles;
    logic [31:0] rng;

    vga_top u_vga_top (.*);

    vga_checker u_checker (
        .clock_a, .clock_b, .rst_n,
        .awready, .wready, .arready,
        .bresp, .bvalid, .bready,
        .rdata, .rresp, .rvalid, .rready,
        .hsync, .vsync, .de, .red, .green, .blue
    );

    // ==============================
    // Clocks and timeout
    // ==============================
    initial begin
        clock_a = 1'b0;
        forever #5 clock_a = ~clock_a;
    end

    initial begin
        clock_b = 1'b0;
        forever #5 clock_b = ~clock_b;
    end

    always @(posedge clock_a) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Hold a ready low for 0 to 7 cycles
    task automatic random_stall();
        rng = xorshift(rng);
        repeat (int'(rng[2:0])) @(posedge clock_a);
    endtask

    // ==============================
    // Input file
    // ==============================
    task automatic load_commands();
        int          fd;
        int          n;
        string       line;
        byte         c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("verif/vga_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/vga_input.txt");
            load_failed = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 1) continue;
            c = line.getc(0);
            a = '0;
            b = '0;
            d = '0;
            e = '0;
            // Comment lines fall through
            case (c)
                "W": n = $sscanf(line, "W %h %h %h %h", a, b, d, e);
                "R": n = $sscanf(line, "R %h %h %h", a, b, d);
                "P": n = $sscanf(line, "P %d %d %h", a, b, d);
                "F": n = 0;
                default: continue;
            endcase
            cmd_q.push_back(c);
            f1_q.push_back(a);
            f2_q.push_back(b);
            f3_q.push_back(d);
            f4_q.push_back(e);
        end
        $fclose(fd);
    endtask

    // ==============================
    // AXI driver
    // ==============================
    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        @(posedge clock_a);
        #1;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge clock_a); while (!awready);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        random_stall();
        #1;
        bready = 1'b1;
        do @(posedge clock_a); while (!bvalid);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr);
        @(posedge clock_a);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge clock_a); while (!arready);
        #1;
        arvalid = 1'b0;
        random_stall();
        #1;
        rready = 1'b1;
        do @(posedge clock_a); while (!rvalid);
        #1;
        rready = 1'b0;
    endtask

    // Frame count moves on falling vsync
    task automatic wait_frames(input int n);
        int target;
        target = u_checker.frames + n;
        while (u_checker.frames < target) @(posedge clock_b);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int n_axi;
        rst_n       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        load_failed = 1'b0;
        cycles      = 0;
        limit       = 0;
        rng         = 32'h9a0f;
        n_axi       = 0;
        load_commands();
        foreach (cmd_q[i]) begin
            if (cmd_q[i] == "W" || cmd_q[i] == "R") n_axi++;
        end
        // Two frames, AXI traffic, reset and margin
        limit = 2 * frame_cycles + 50 * n_axi + 5000;
        repeat (10) @(posedge clock_a);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clock_a);
        #1;
        u_checker.check_idle();
        foreach (cmd_q[i]) begin
            case (cmd_q[i])
                "W": begin
                    u_checker.expect_write(f4_q[i][1:0]);
                    axi_write(f1_q[i][15:0], f2_q[i], f3_q[i][3:0]);
                    u_checker.finish_test($sformatf("write %h", f1_q[i][15:0]));
                end
                "R": begin
                    u_checker.expect_read(f2_q[i], f3_q[i][1:0]);
                    axi_read(f1_q[i][15:0]);
                    u_checker.finish_test($sformatf("read %h", f1_q[i][15:0]));
                end
                "P": u_checker.expect_pixel(f1_q[i], f2_q[i], f3_q[i][11:0]);
                default: begin
                    wait_frames(2);
                    u_checker.finish_test("frame wait");
                end
            endcase
        end
        u_checker.final_check();
        u_checker.report();
        if (u_checker.errors == 0 && !load_failed) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
